//--- src/weight_rotator_pkg.sv
package weight_rotator_pkg;

  // one weight per stream beat
  localparam int WORD_WIDTH = 16;

  // header field widths
  localparam int KW2_BITS  = 3;
  localparam int CIN_BITS  = 4;
  localparam int COLS_BITS = 5;
  localparam int SPARE_BITS = WORD_WIDTH - KW2_BITS - CIN_BITS - COLS_BITS;

  // words per bank
  localparam int RAM_DEPTH = 64;

  // a stream beat is either the header or a weight
  typedef union packed {
    logic signed [WORD_WIDTH-1:0] weight;
    struct packed {
      logic [SPARE_BITS-1:0] spare;
      // repeats minus one
      logic [COLS_BITS-1:0]  cols_1;
      // input channels minus one
      logic [CIN_BITS-1:0]   cin_1;
      // kernel width is 2*kw2+1
      logic [KW2_BITS-1:0]   kw2;
    } header;
  } stream_word_u;

endpackage

//--- src/weight_header_decoder.sv
`timescale 1ns/1ps

module weight_header_decoder import weight_rotator_pkg::*; #(
  parameter int  RAM_DEPTH = weight_rotator_pkg::RAM_DEPTH,
  localparam int ADDR_BITS = $clog2(RAM_DEPTH)
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  i_capture,
  input  logic                  i_wr_bank,
  input  stream_word_u          i_s_data,
  input  logic                  i_rd_bank_sel,
  output logic [ADDR_BITS-1:0]  o_len_last,
  output logic [KW2_BITS-1:0]   o_rd_kw2,
  output logic [CIN_BITS-1:0]   o_rd_cin_1,
  output logic [COLS_BITS-1:0]  o_rd_cols_1
);

  localparam int KW_BITS  = KW2_BITS + 1;
  localparam int CH_BITS  = CIN_BITS + 1;
  localparam int LEN_BITS = KW_BITS + CH_BITS;

  logic [KW_BITS-1:0]  kw;
  logic [CH_BITS-1:0]  ch;
  logic [LEN_BITS-1:0] len;
  logic [LEN_BITS-1:0] len_m1;

  // reference registers, one set per bank
  logic [1:0][KW2_BITS-1:0]  ref_kw2;
  logic [1:0][CIN_BITS-1:0]  ref_cin_1;
  logic [1:0][COLS_BITS-1:0] ref_cols_1;
  logic [1:0][ADDR_BITS-1:0] ref_len_last;

  // words per bank = kw * channels
  assign kw     = {i_s_data.header.kw2, 1'b1};
  assign ch     = CH_BITS'(i_s_data.header.cin_1) + CH_BITS'(1);
  assign len    = kw * ch;
  assign len_m1 = len - LEN_BITS'(1);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ref_kw2      <= '0;
      ref_cin_1    <= '0;
      ref_cols_1   <= '0;
      ref_len_last <= '0;
    end else if (i_capture) begin
      ref_kw2[i_wr_bank]      <= i_s_data.header.kw2;
      ref_cin_1[i_wr_bank]    <= i_s_data.header.cin_1;
      ref_cols_1[i_wr_bank]   <= i_s_data.header.cols_1;
      ref_len_last[i_wr_bank] <= ADDR_BITS'(len_m1);
    end
  end

  assign o_len_last  = ref_len_last[i_wr_bank];

  // fields of the bank under read-out
  assign o_rd_kw2    = ref_kw2[i_rd_bank_sel];
  assign o_rd_cin_1  = ref_cin_1[i_rd_bank_sel];
  assign o_rd_cols_1 = ref_cols_1[i_rd_bank_sel];

endmodule

//--- src/weight_bank_ram.sv
`timescale 1ns/1ps

module weight_bank_ram import weight_rotator_pkg::*; #(
  parameter int  RAM_DEPTH = weight_rotator_pkg::RAM_DEPTH,
  localparam int ADDR_BITS = $clog2(RAM_DEPTH)
) (
  input  logic                  aclk,
  input  logic                  i_we,
  input  logic                  i_wbank,
  input  logic [ADDR_BITS-1:0]  i_waddr,
  input  logic [WORD_WIDTH-1:0] i_wdata,
  input  logic                  i_re,
  input  logic                  i_rbank,
  input  logic [ADDR_BITS-1:0]  i_raddr,
  output logic [WORD_WIDTH-1:0] o_rdata
);

  // both banks in one array, bank select is the top address bit
  logic [WORD_WIDTH-1:0] mem [2*RAM_DEPTH];

  always_ff @(posedge aclk) begin
    if (i_we) begin
      mem[{i_wbank, i_waddr}] <= i_wdata;
    end
  end

  // registered read, holds when not enabled
  always_ff @(posedge aclk) begin
    if (i_re) begin
      o_rdata <= mem[{i_rbank, i_raddr}];
    end
  end

endmodule

//--- src/weight_bank_writer.sv
`timescale 1ns/1ps

module weight_bank_writer import weight_rotator_pkg::*; #(
  parameter int  RAM_DEPTH = weight_rotator_pkg::RAM_DEPTH,
  localparam int ADDR_BITS = $clog2(RAM_DEPTH)
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  i_s_valid,
  input  logic                  i_s_last,
  input  stream_word_u          i_s_data,
  input  logic [ADDR_BITS-1:0]  i_len_last,
  input  logic [1:0]            i_free,
  output logic                  o_s_ready,
  output logic                  o_capture,
  output logic                  o_wr_bank,
  output logic                  o_we,
  output logic [ADDR_BITS-1:0]  o_waddr,
  output logic                  o_wbank,
  output logic [WORD_WIDTH-1:0] o_wdata,
  output logic [1:0]            o_full
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_HEADER,
    W_WRITE,
    W_SWITCH
  } wr_state_e;

  wr_state_e            state;
  logic                 wr_bank;
  logic [ADDR_BITS-1:0] waddr;
  logic [1:0]           full;
  logic                 s_hs;

  assign o_s_ready = (state == W_HEADER) || (state == W_WRITE);
  assign s_hs      = i_s_valid && o_s_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= W_IDLE;
      wr_bank <= 1'b0;
      waddr   <= '0;
      full    <= '0;
    end else begin
      case (state)
        // wait until the reader has released this bank
        W_IDLE: begin
          if (i_free[wr_bank]) begin
            full[wr_bank] <= 1'b0;
            state         <= W_HEADER;
          end
        end
        W_HEADER: begin
          if (s_hs) begin
            waddr <= '0;
            state <= W_WRITE;
          end
        end
        W_WRITE: begin
          if (s_hs) begin
            // stays on the last slot if the stream runs long
            if (waddr != i_len_last) begin
              waddr <= waddr + 1'b1;
            end
            if (i_s_last) begin
              state <= W_SWITCH;
            end
          end
        end
        W_SWITCH: begin
          full[wr_bank] <= 1'b1;
          wr_bank       <= !wr_bank;
          state         <= W_IDLE;
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  assign o_capture = (state == W_HEADER) && i_s_valid;
  assign o_we      = (state == W_WRITE) && i_s_valid;
  assign o_waddr   = waddr;
  assign o_wbank   = wr_bank;
  assign o_wr_bank = wr_bank;
  assign o_wdata   = i_s_data.weight;
  assign o_full    = full;

endmodule

//--- src/weight_rotation_reader.sv
`timescale 1ns/1ps

module weight_rotation_reader import weight_rotator_pkg::*; #(
  parameter int  RAM_DEPTH = weight_rotator_pkg::RAM_DEPTH,
  localparam int ADDR_BITS = $clog2(RAM_DEPTH)
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic [1:0]            i_full,
  input  logic [KW2_BITS-1:0]   i_kw2,
  input  logic [CIN_BITS-1:0]   i_cin_1,
  input  logic [COLS_BITS-1:0]  i_cols_1,
  input  logic [WORD_WIDTH-1:0] i_rdata,
  input  logic                  i_m_ready,
  output logic [1:0]            o_free,
  output logic                  o_rd_bank_sel,
  output logic                  o_re,
  output logic [ADDR_BITS-1:0]  o_raddr,
  output logic                  o_rbank,
  output logic                  o_m_valid,
  output logic [WORD_WIDTH-1:0] o_m_data,
  output logic                  o_m_last,
  output logic                  o_m_first,
  output logic                  o_m_cin_last,
  output logic                  o_m_w_last
);

  localparam int KW_BITS = KW2_BITS + 1;

  typedef enum logic [1:0] {
    R_IDLE,
    R_READ,
    R_SWITCH
  } rd_state_e;

  rd_state_e             state;
  logic                  rd_bank;
  logic [1:0]            free;
  logic [KW_BITS-1:0]    c_kw;
  logic [CIN_BITS-1:0]   c_cin;
  logic [COLS_BITS-1:0]  c_cols;
  logic [ADDR_BITS-1:0]  raddr;
  logic                  issued_all;
  logic                  kw_last;
  logic                  cin_last;
  logic                  cols_last;
  logic                  advance;
  logic                  issue;

  // RAM stage and output register
  logic                  s1_valid;
  logic                  s1_first;
  logic                  s1_cin_last;
  logic                  s1_w_last;
  logic                  s1_last;
  logic                  m_valid;
  logic [WORD_WIDTH-1:0] m_data;
  logic                  m_first;
  logic                  m_cin_last;
  logic                  m_w_last;
  logic                  m_last;

  assign kw_last   = (c_kw == {i_kw2, 1'b0});
  assign cin_last  = (c_cin == i_cin_1);
  assign cols_last = (c_cols == i_cols_1);

  // pipeline moves when the output register is empty or taken
  assign advance = !m_valid || i_m_ready;
  assign issue   = advance && (((state == R_IDLE) && i_full[rd_bank]) ||
                               ((state == R_READ) && !issued_all));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= R_IDLE;
      rd_bank    <= 1'b0;
      free       <= 2'b11;
      c_kw       <= '0;
      c_cin      <= '0;
      c_cols     <= '0;
      raddr      <= '0;
      issued_all <= 1'b0;
    end else begin
      case (state)
        R_IDLE: begin
          if (issue) begin
            free[rd_bank] <= 1'b0;
            state         <= R_READ;
          end
        end
        R_READ: begin
          if (m_valid && i_m_ready && m_last) begin
            state <= R_SWITCH;
          end
        end
        R_SWITCH: begin
          free[rd_bank] <= 1'b1;
          rd_bank       <= !rd_bank;
          issued_all    <= 1'b0;
          state         <= R_IDLE;
        end
        default: state <= R_IDLE;
      endcase

      // kw fastest, then channel, then repeat
      // all counters wrap back to zero after the final read
      if (issue) begin
        if (kw_last) begin
          c_kw <= '0;
          if (cin_last) begin
            c_cin <= '0;
            raddr <= '0;
            if (cols_last) begin
              c_cols     <= '0;
              issued_all <= 1'b1;
            end else begin
              c_cols <= c_cols + 1'b1;
            end
          end else begin
            c_cin <= c_cin + 1'b1;
            raddr <= raddr + 1'b1;
          end
        end else begin
          c_kw  <= c_kw + 1'b1;
          raddr <= raddr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s1_valid <= 1'b0;
      m_valid  <= 1'b0;
    end else if (advance) begin
      s1_valid <= issue;
      m_valid  <= s1_valid;
    end
  end

  // flags follow the word through the RAM stage
  always_ff @(posedge aclk) begin
    if (issue) begin
      s1_first    <= (c_kw == '0) && (c_cin == '0) && (c_cols == '0);
      s1_cin_last <= kw_last && cin_last;
      s1_w_last   <= cols_last;
      s1_last     <= kw_last && cin_last && cols_last;
    end
    if (advance) begin
      m_data     <= i_rdata;
      m_first    <= s1_first;
      m_cin_last <= s1_cin_last;
      m_w_last   <= s1_w_last;
      m_last     <= s1_last;
    end
  end

  assign o_free        = free;
  assign o_rd_bank_sel = rd_bank;
  assign o_re          = issue;
  assign o_raddr       = raddr;
  assign o_rbank       = rd_bank;
  assign o_m_valid     = m_valid;
  assign o_m_data      = m_data;
  assign o_m_first     = m_first;
  assign o_m_cin_last  = m_cin_last;
  assign o_m_w_last    = m_w_last;
  assign o_m_last      = m_last;

endmodule

//--- src/weight_rotator.sv
`timescale 1ns/1ps

module weight_rotator import weight_rotator_pkg::*; #(
  parameter int  RAM_DEPTH = weight_rotator_pkg::RAM_DEPTH,
  localparam int ADDR_BITS = $clog2(RAM_DEPTH)
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  i_s_valid,
  output logic                  o_s_ready,
  input  logic [WORD_WIDTH-1:0] i_s_data,
  input  logic                  i_s_last,
  output logic                  o_m_valid,
  input  logic                  i_m_ready,
  output logic [WORD_WIDTH-1:0] o_m_data,
  output logic                  o_m_last,
  output logic                  o_m_first,
  output logic                  o_m_cin_last,
  output logic                  o_m_w_last
);

  logic                  capture;
  logic                  wr_bank;
  logic [ADDR_BITS-1:0]  len_last;
  logic                  we;
  logic [ADDR_BITS-1:0]  waddr;
  logic                  wbank;
  logic [WORD_WIDTH-1:0] wdata;
  logic [1:0]            full;
  logic [1:0]            free;
  logic                  re;
  logic [ADDR_BITS-1:0]  raddr;
  logic                  rbank;
  logic [WORD_WIDTH-1:0] rdata;
  logic                  rd_bank_sel;
  logic [KW2_BITS-1:0]   rd_kw2;
  logic [CIN_BITS-1:0]   rd_cin_1;
  logic [COLS_BITS-1:0]  rd_cols_1;

  weight_header_decoder #(.RAM_DEPTH(RAM_DEPTH)) u_decoder (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_capture     (capture),
    .i_wr_bank     (wr_bank),
    .i_s_data      (i_s_data),
    .i_rd_bank_sel (rd_bank_sel),
    .o_len_last    (len_last),
    .o_rd_kw2      (rd_kw2),
    .o_rd_cin_1    (rd_cin_1),
    .o_rd_cols_1   (rd_cols_1)
  );

  weight_bank_writer #(.RAM_DEPTH(RAM_DEPTH)) u_writer (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_s_valid  (i_s_valid),
    .i_s_last   (i_s_last),
    .i_s_data   (i_s_data),
    .i_len_last (len_last),
    .i_free     (free),
    .o_s_ready  (o_s_ready),
    .o_capture  (capture),
    .o_wr_bank  (wr_bank),
    .o_we       (we),
    .o_waddr    (waddr),
    .o_wbank    (wbank),
    .o_wdata    (wdata),
    .o_full     (full)
  );

  weight_bank_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
    .aclk    (aclk),
    .i_we    (we),
    .i_wbank (wbank),
    .i_waddr (waddr),
    .i_wdata (wdata),
    .i_re    (re),
    .i_rbank (rbank),
    .i_raddr (raddr),
    .o_rdata (rdata)
  );

  weight_rotation_reader #(.RAM_DEPTH(RAM_DEPTH)) u_reader (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_full        (full),
    .i_kw2         (rd_kw2),
    .i_cin_1       (rd_cin_1),
    .i_cols_1      (rd_cols_1),
    .i_rdata       (rdata),
    .i_m_ready     (i_m_ready),
    .o_free        (free),
    .o_rd_bank_sel (rd_bank_sel),
    .o_re          (re),
    .o_raddr       (raddr),
    .o_rbank       (rbank),
    .o_m_valid     (o_m_valid),
    .o_m_data      (o_m_data),
    .o_m_last      (o_m_last),
    .o_m_first     (o_m_first),
    .o_m_cin_last  (o_m_cin_last),
    .o_m_w_last    (o_m_w_last)
  );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 16
) (
  output logic o_aclk,
  output logic o_aresetn
);

  initial begin
    o_aclk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_aclk = ~o_aclk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    o_aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_aclk);
    @(negedge o_aclk);
    o_aresetn <= 1'b1;
  end

endmodule

//--- verification/weight_rotator_sva.sv
`timescale 1ns/1ps

module weight_rotator_sva import weight_rotator_pkg::*; (
  input logic                  aclk,
  input logic                  aresetn,
  input logic [1:0]            i_full,
  input logic                  i_re,
  input logic                  i_rbank,
  input logic                  i_m_ready,
  input logic                  i_m_valid,
  input logic [WORD_WIDTH-1:0] i_m_data,
  input logic                  i_m_first,
  input logic                  i_m_cin_last,
  input logic                  i_m_w_last,
  input logic                  i_m_last
);

  logic [WORD_WIDTH+3:0] out_word;
  logic                  expect_first;

  assign out_word = {i_m_data, i_m_first, i_m_cin_last, i_m_w_last, i_m_last};

  // next taken beat opens a stream after reset or after o_m_last
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      expect_first <= 1'b1;
    end else if (i_m_valid && i_m_ready) begin
      expect_first <= i_m_last;
    end
  end

  // stalled beat stays put until taken
  hold_under_stall: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid && !i_m_ready |=> i_m_valid && $stable(out_word))
    else $error("output beat changed or dropped while stalled");

  // o_m_first marks exactly the beat after the previous end
  first_after_last: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid && i_m_ready |-> i_m_first == expect_first)
    else $error("o_m_first does not match the position after o_m_last");

  // reads only from a written bank
  read_from_full_bank: assert property (@(posedge aclk) disable iff (!aresetn)
    i_re |-> i_full[i_rbank])
    else $error("RAM read from a bank that is not full");

endmodule

bind weight_rotation_reader weight_rotator_sva u_sva (
  .aclk         (aclk),
  .aresetn      (aresetn),
  .i_full       (i_full),
  .i_re         (o_re),
  .i_rbank      (o_rbank),
  .i_m_ready    (i_m_ready),
  .i_m_valid    (o_m_valid),
  .i_m_data     (o_m_data),
  .i_m_first    (o_m_first),
  .i_m_cin_last (o_m_cin_last),
  .i_m_w_last   (o_m_w_last),
  .i_m_last     (o_m_last)
);

//--- verification/tb_weight_rotator.sv
`timescale 1ns/1ps

module tb_weight_rotator import weight_rotator_pkg::*;;

  localparam int          MAX_TESTS       = 16;
  localparam int          PAT_DEPTH       = 256;
  localparam int          CYCLES_PER_BEAT = 20;
  localparam int          TIMEOUT_MARGIN  = 200;
  localparam int          DRAIN_CYCLES    = 20;
  localparam logic [31:0] LFSR_SEED       = 32'h7105_f703;
  localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;

  logic                  aclk;
  logic                  aresetn;
  logic                  i_s_valid;
  logic                  o_s_ready;
  logic [WORD_WIDTH-1:0] i_s_data;
  logic                  i_s_last;
  logic                  o_m_valid;
  logic                  i_m_ready;
  logic [WORD_WIDTH-1:0] o_m_data;
  logic                  o_m_last;
  logic                  o_m_first;
  logic                  o_m_cin_last;
  logic                  o_m_w_last;

  // parsed pattern records
  logic [WORD_WIDTH-1:0] pat_mem [PAT_DEPTH];
  int                    n_tests;
  int                    t_start  [MAX_TESTS];
  int                    t_nw     [MAX_TESTS];
  logic [WORD_WIDTH-1:0] t_header [MAX_TESTS];
  int                    t_stall  [MAX_TESTS];
  int                    t_beats  [MAX_TESTS];
  int                    timeout_cycles;
  logic                  patterns_loaded;

  logic [31:0]           lfsr;
  int                    error_count;
  int                    test_errors;
  int                    beats_checked;

  // input side
  int                    in_test;
  int                    in_pos;
  logic                  s_accept;
  int                    streams_written;
  int                    overlaps;

  // output side
  int                    out_test;
  int                    out_beat;
  int                    last_seen;
  logic                  hold_pending;
  logic [WORD_WIDTH-1:0] held_data;
  logic [3:0]            held_flags;

  tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(16)) u_clock (
    .o_aclk    (aclk),
    .o_aresetn (aresetn)
  );

  weight_rotator #(.RAM_DEPTH(64)) i_dut (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .i_s_valid    (i_s_valid),
    .o_s_ready    (o_s_ready),
    .i_s_data     (i_s_data),
    .i_s_last     (i_s_last),
    .o_m_valid    (o_m_valid),
    .i_m_ready    (i_m_ready),
    .o_m_data     (o_m_data),
    .o_m_last     (o_m_last),
    .o_m_first    (o_m_first),
    .o_m_cin_last (o_m_cin_last),
    .o_m_w_last   (o_m_w_last)
  );

  // header layout {spare, cols_1[11:7], cin_1[6:3], kw2[2:0]}
  function automatic int kw_of(logic [WORD_WIDTH-1:0] h);
    return 2 * int'(h[2:0]) + 1;
  endfunction

  function automatic int ch_of(logic [WORD_WIDTH-1:0] h);
    return int'(h[6:3]) + 1;
  endfunction

  function automatic int reps_of(logic [WORD_WIDTH-1:0] h);
    return int'(h[11:7]) + 1;
  endfunction

  function automatic logic take_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ LFSR_TAPS;
    end
    return b;
  endfunction

  task automatic note_mismatch(string msg);
    error_count++;
    test_errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  task automatic note_failure(string msg);
    error_count++;
    test_errors++;
    $display("%s", msg);
  endtask

  task automatic load_patterns();
    int p;
    int i;
    int n;
    int rule_beats;
    logic [WORD_WIDTH-1:0] h;
    p = 0;
    n_tests = 0;
    timeout_cycles = TIMEOUT_MARGIN;
    for (i = 0; i < PAT_DEPTH; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("verification/weight_patterns.txt", pat_mem);
    while (pat_mem[p] != '0 && n_tests < MAX_TESTS && p + 4 < PAT_DEPTH) begin
      n = int'(pat_mem[p]);
      h = pat_mem[p+1];
      rule_beats = kw_of(h) * ch_of(h) * reps_of(h);
      t_nw[n_tests]     = n;
      t_header[n_tests] = h;
      t_stall[n_tests]  = int'(pat_mem[p+2]) & 3;
      t_beats[n_tests]  = rule_beats;
      t_start[n_tests]  = p + 4;
      if (n != kw_of(h) * ch_of(h)) begin
        note_failure($sformatf("pattern test %0d holds %0d weights but its header asks for %0d",
                               n_tests, n, kw_of(h) * ch_of(h)));
      end
      if (int'(pat_mem[p+3]) != rule_beats) begin
        note_failure($sformatf("pattern test %0d lists %0d beats but the header gives %0d",
                               n_tests, int'(pat_mem[p+3]), rule_beats));
      end
      timeout_cycles += CYCLES_PER_BEAT * rule_beats;
      p = p + 4 + n;
      n_tests++;
    end
    if (n_tests == 0) begin
      note_failure("no tests found in verification/weight_patterns.txt");
    end
  endtask

  // ready stall level 0..3 per test, drawn as two bits
  task automatic drive_ready();
    int level;
    logic [1:0] draw;
    level = (out_test < n_tests) ? t_stall[out_test] : 0;
    if (level == 0) begin
      i_m_ready = 1'b1;
    end else begin
      draw[0] = take_bit();
      draw[1] = take_bit();
      i_m_ready = (int'(draw) >= level);
    end
  endtask

  task automatic finish_test();
    logic [WORD_WIDTH-1:0] h;
    h = t_header[out_test];
    if (last_seen != 1) begin
      note_failure($sformatf("test %0d: o_m_last seen %0d times instead of once",
                             out_test, last_seen));
    end
    $display("test %0d done: kw %0d, channels %0d, repeats %0d, %0d beats, %0d errors",
             out_test, kw_of(h), ch_of(h), reps_of(h), t_beats[out_test], test_errors);
    out_test++;
    out_beat = 0;
    last_seen = 0;
    test_errors = 0;
  endtask

  task automatic check_beat();
    logic [WORD_WIDTH-1:0] h;
    logic [WORD_WIDTH-1:0] exp_data;
    logic [3:0]            exp_flags;
    int kw;
    int ch;
    int per;
    int rep;
    int pos_c;
    int pos_k;
    logic cin_end;
    h = t_header[out_test];
    kw = kw_of(h);
    ch = ch_of(h);
    per = kw * ch;
    rep = out_beat / per;
    pos_c = (out_beat % per) / kw;
    pos_k = (out_beat % per) % kw;
    exp_data = pat_mem[t_start[out_test] + pos_c * kw + pos_k];
    cin_end = (pos_k == kw - 1) && (pos_c == ch - 1);
    exp_flags = {(rep == 0) && (pos_c == 0) && (pos_k == 0), cin_end,
                 rep == reps_of(h) - 1, cin_end && (rep == reps_of(h) - 1)};
    if (out_beat == 0 && streams_written <= out_test) begin
      note_failure($sformatf("test %0d output started before its stream was written",
                             out_test));
    end
    if (o_m_data !== exp_data) begin
      note_mismatch($sformatf("test %0d beat %0d data %h, expected %h",
                              out_test, out_beat, o_m_data, exp_data));
    end
    if ({o_m_first, o_m_cin_last, o_m_w_last, o_m_last} !== exp_flags) begin
      note_mismatch($sformatf("test %0d beat %0d flags first/cin/w/last %b, expected %b",
                              out_test, out_beat,
                              {o_m_first, o_m_cin_last, o_m_w_last, o_m_last}, exp_flags));
    end
    if (o_m_last === 1'b1) begin
      last_seen++;
    end
    beats_checked++;
    out_beat++;
    if (out_beat == t_beats[out_test]) begin
      finish_test();
    end
  endtask

  task automatic check_output();
    logic [3:0] flags;
    flags = {o_m_first, o_m_cin_last, o_m_w_last, o_m_last};
    if (hold_pending) begin
      if (o_m_valid !== 1'b1) begin
        note_failure($sformatf("o_m_valid dropped at %0t before a stalled beat was taken",
                               $time));
      end else if (o_m_data !== held_data || flags !== held_flags) begin
        note_mismatch("output beat changed while i_m_ready was low");
      end
    end
    hold_pending = 1'b0;
    if (o_m_valid === 1'b1) begin
      if (out_test >= n_tests) begin
        note_failure($sformatf("unexpected output beat at %0t after the last stream", $time));
      end else if (i_m_ready) begin
        check_beat();
      end else begin
        hold_pending = 1'b1;
        held_data = o_m_data;
        held_flags = flags;
      end
    end
  endtask

  // one beat per stream slot: header first, then the weights
  task automatic drive_input();
    logic [1:0] gap;
    if (s_accept) begin
      if (in_pos == 0 && in_test > 0 && out_test < in_test) begin
        overlaps++;
      end
      if (in_pos == t_nw[in_test]) begin
        streams_written++;
        in_test++;
        in_pos = 0;
      end else begin
        in_pos++;
      end
    end
    if (!i_s_valid || s_accept) begin
      gap[0] = take_bit();
      gap[1] = take_bit();
      if (in_test < n_tests && gap != 2'b11) begin
        i_s_valid = 1'b1;
        i_s_data = (in_pos == 0) ? t_header[in_test] :
                                   pat_mem[t_start[in_test] + in_pos - 1];
        i_s_last = (in_pos != 0) && (in_pos == t_nw[in_test]);
      end else begin
        i_s_valid = 1'b0;
        i_s_data = '0;
        i_s_last = 1'b0;
      end
    end
    s_accept = (i_s_valid === 1'b1) && (o_s_ready === 1'b1);
  endtask

  initial begin : main
    i_s_valid = 1'b0;
    i_s_data = '0;
    i_s_last = 1'b0;
    i_m_ready = 1'b0;
    lfsr = LFSR_SEED;
    error_count = 0;
    test_errors = 0;
    beats_checked = 0;
    in_test = 0;
    in_pos = 0;
    s_accept = 1'b0;
    streams_written = 0;
    overlaps = 0;
    out_test = 0;
    out_beat = 0;
    last_seen = 0;
    hold_pending = 1'b0;
    patterns_loaded = 1'b0;
    load_patterns();
    patterns_loaded = 1'b1;
    @(negedge aclk);
    while (aresetn !== 1'b1) begin
      if (o_m_valid !== 1'b0 || o_s_ready !== 1'b0) begin
        note_failure("o_m_valid or o_s_ready not low during reset");
      end
      @(negedge aclk);
    end
    test_errors = 0;
    while (out_test < n_tests) begin
      drive_ready();
      check_output();
      drive_input();
      @(negedge aclk);
    end
    // nothing more may come out
    repeat (DRAIN_CYCLES) begin
      i_m_ready = 1'b1;
      check_output();
      @(negedge aclk);
    end
    if (n_tests > 1 && overlaps == 0) begin
      note_failure("no stream was accepted while the previous one was still being read");
    end
    $display("summary: %0d tests, %0d beats checked, %0d failed checks",
             out_test, beats_checked, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    wait (patterns_loaded === 1'b1);
    repeat (timeout_cycles) @(posedge aclk);
    $display("timeout: the output streams did not complete within %0d cycles",
             timeout_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- src.f
src/weight_rotator_pkg.sv
src/weight_header_decoder.sv
src/weight_bank_ram.sv
src/weight_bank_writer.sv
src/weight_rotation_reader.sv
src/weight_rotator.sv
verification/tb_clock_gen.sv
verification/weight_rotator_sva.sv
verification/tb_weight_rotator.sv

//--- Makefile
TOP = tb_weight_rotator
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- verification/weight_patterns.txt
// per test: weight count, header, ready stall level 0-3, expected output beats, weights
// header is {spare[15:12], cols_1[11:7], cin_1[6:3], kw2[2:0]}, a zero count ends the list

// kw 3, 2 channels, 3 repeats, back to back with the next test
0006 0109 0000 0012
0101 0102 0103
0111 0112 0113

// kw 1, 4 channels, 2 repeats, half the cycles stalled
0004 0098 0002 0008
0201
0211
0221
0231

// kw 5, 3 channels, 1 repeat, negative weights, heavy stalls
000f 0012 0003 000f
f301 f302 f303 f304 f305
f311 f312 f313 f314 f315
f321 f322 f323 f324 f325

// kw 3, 1 channel, 4 repeats, extreme values
0003 0181 0001 000c
7ff0 8001 0400

// single weight, single repeat
0001 0000 0002 0001
5a5a

// end of list
0000
